// ==== source/link_defs.svh ====
`ifndef LINK_DEFS_SVH
`define LINK_DEFS_SVH

// Width of one token value on the link
`define LINK_DATA_W 16

// Receiver FIFO depths, which are also the sender's starting credits
`define DATA_FIFO_DEPTH 4
`define MARK_FIFO_DEPTH 2

`endif

// ==== source/linkPkg.sv ====
`include "link_defs.svh"

package linkPkg;

  // One data token as it travels over the link
  typedef struct packed {
    logic [`LINK_DATA_W-1:0] value;
    logic                    last;
  } dataToken_t;

  // Sender FSM states
  // EndMark waits for a mark credit after a token with last set
  typedef enum logic {
    Data,
    EndMark
  } senderState_t;

endpackage

// ==== source/creditLinkIf.sv ====
`timescale 1ns/10ps

interface creditLinkIf;

  // Forward direction, one pulse per token
  logic                dataValid;
  linkPkg::dataToken_t dataToken;
  logic                markValid;

  // Return direction, one pulse per freed slot
  logic dataCredit;
  logic markCredit;

  modport sender (
    output dataValid,
    output dataToken,
    output markValid,
    input  dataCredit,
    input  markCredit
  );

  modport receiver (
    input  dataValid,
    input  dataToken,
    input  markValid,
    output dataCredit,
    output markCredit
  );

endinterface

// ==== source/creditCounter.sv ====
`timescale 1ns/10ps

module creditCounter #(
  parameter int DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic spend,
  input  logic refund,
  output logic available
);

  localparam int CntW = $clog2(DEPTH + 1);

  logic [CntW-1:0] count;

  // Starts full since the far FIFO is empty after reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= CntW'(DEPTH);
    end else begin
      case ({spend, refund})
        2'b10: count <= count - 1'b1;
        2'b01: count <= count + 1'b1;
        // Spend and refund together cancel out
        default: count <= count;
      endcase
    end
  end

  assign available = (count != '0);

  // Spending with no credit means the far FIFO could overflow
  noUnderflow: assert property (
    @(posedge clk) disable iff (rst)
    spend |-> available
  ) else $error("creditCounter spent a credit it did not hold");

  // More refunds than spends means the receiver returned a slot twice
  noExcess: assert property (
    @(posedge clk) disable iff (rst)
    count <= CntW'(DEPTH)
  ) else $error("creditCounter count %0d above depth %0d", count, DEPTH);

endmodule

// ==== source/linkSender.sv ====
`timescale 1ns/10ps
`include "link_defs.svh"

module linkSender (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    inValid,
  output logic                    inReady,
  input  logic [`LINK_DATA_W-1:0] inData,
  input  logic                    inLast,
  creditLinkIf.sender             link
);

  linkPkg::senderState_t state;
  linkPkg::dataToken_t   tokenQ;
  logic                  dataValidQ;
  logic                  dataAvail;
  logic                  markAvail;
  logic                  accept;
  logic                  markSend;

  creditCounter #(
    .DEPTH(`DATA_FIFO_DEPTH)
  ) dataCredits (
    .clk(clk),
    .rst(rst),
    .spend(accept),
    .refund(link.dataCredit),
    .available(dataAvail)
  );

  creditCounter #(
    .DEPTH(`MARK_FIFO_DEPTH)
  ) markCredits (
    .clk(clk),
    .rst(rst),
    .spend(markSend),
    .refund(link.markCredit),
    .available(markAvail)
  );

  // Input is only taken in Data and only with a free data slot
  assign inReady  = (state == linkPkg::Data) && dataAvail;
  assign accept   = inValid && inReady;

  // Mark goes out in the EndMark cycle that holds a mark credit
  assign markSend = (state == linkPkg::EndMark) && markAvail;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= linkPkg::Data;
    end else begin
      case (state)
        linkPkg::Data: begin
          if (accept && inLast) begin
            state <= linkPkg::EndMark;
          end
        end
        linkPkg::EndMark: begin
          if (markAvail) begin
            state <= linkPkg::Data;
          end
        end
        default: state <= linkPkg::Data;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dataValidQ <= 1'b0;
    end else begin
      dataValidQ <= accept;
    end
  end

  // Token payload is captured on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      tokenQ.value <= inData;
      tokenQ.last  <= inLast;
    end
  end

  assign link.dataValid = dataValidQ;
  assign link.dataToken = tokenQ;
  assign link.markValid = markSend;

endmodule

// ==== source/elasticFifo.sv ====
`timescale 1ns/10ps

module elasticFifo #(
  parameter int SIZE = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                insValid,
  input  linkPkg::dataToken_t insData,
  output logic                insReady,
  output logic                outsValid,
  output linkPkg::dataToken_t outsData,
  input  logic                outsReady
);

  localparam int PtrW = (SIZE > 1) ? $clog2(SIZE) : 1;

  linkPkg::dataToken_t mem [SIZE];
  logic [PtrW-1:0]     head;
  logic [PtrW-1:0]     tail;
  logic [PtrW-1:0]     headNext;
  logic [PtrW-1:0]     tailNext;
  logic                full;
  logic                empty;
  logic                writeEn;
  logic                readEn;

  // A full FIFO still takes a write when the head leaves this cycle
  assign insReady  = !full || outsReady;
  assign writeEn   = insValid && insReady;
  assign readEn    = outsReady && !empty;
  assign outsValid = !empty;
  assign outsData  = mem[head];

  // Pointer wrap works for any SIZE, not only powers of two
  assign headNext = (head == PtrW'(SIZE - 1)) ? '0 : head + 1'b1;
  assign tailNext = (tail == PtrW'(SIZE - 1)) ? '0 : tail + 1'b1;

  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[tail] <= insData;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end else begin
      if (writeEn) begin
        tail <= tailNext;
      end
      if (readEn) begin
        head <= headNext;
      end
      // Flags only move when occupancy changes
      if (writeEn && !readEn) begin
        empty <= 1'b0;
        if (tailNext == head) begin
          full <= 1'b1;
        end
      end else if (readEn && !writeEn) begin
        full <= 1'b0;
        if (headNext == tail) begin
          empty <= 1'b1;
        end
      end
    end
  end

  noOverflow: assert property (
    @(posedge clk) disable iff (rst)
    insValid |-> insReady
  ) else $error("elasticFifo write while full");

endmodule

// ==== source/elasticFifoDataless.sv ====
`timescale 1ns/10ps

module elasticFifoDataless #(
  parameter int SIZE = 2
) (
  input  logic clk,
  input  logic rst,
  input  logic insValid,
  output logic insReady,
  output logic outsValid,
  input  logic outsReady
);

  localparam int PtrW = (SIZE > 1) ? $clog2(SIZE) : 1;

  logic [PtrW-1:0] head;
  logic [PtrW-1:0] tail;
  logic [PtrW-1:0] headNext;
  logic [PtrW-1:0] tailNext;
  logic            full;
  logic            empty;
  logic            writeEn;
  logic            readEn;

  // Only occupancy is tracked, the tokens carry no payload
  assign insReady  = !full || outsReady;
  assign writeEn   = insValid && insReady;
  assign readEn    = outsReady && !empty;
  assign outsValid = !empty;

  assign headNext = (head == PtrW'(SIZE - 1)) ? '0 : head + 1'b1;
  assign tailNext = (tail == PtrW'(SIZE - 1)) ? '0 : tail + 1'b1;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end else begin
      if (writeEn) begin
        tail <= tailNext;
      end
      if (readEn) begin
        head <= headNext;
      end
      if (writeEn && !readEn) begin
        empty <= 1'b0;
        // Tail catching up with head means every slot is taken
        if (tailNext == head) begin
          full <= 1'b1;
        end
      end else if (readEn && !writeEn) begin
        full <= 1'b0;
        if (headNext == tail) begin
          empty <= 1'b1;
        end
      end
    end
  end

  noOverflow: assert property (
    @(posedge clk) disable iff (rst)
    insValid |-> insReady
  ) else $error("elasticFifoDataless write while full");

endmodule

// ==== source/linkReceiver.sv ====
`timescale 1ns/10ps
`include "link_defs.svh"

module linkReceiver (
  input  logic                    clk,
  input  logic                    rst,
  creditLinkIf.receiver           link,
  output logic                    outValid,
  input  logic                    outReady,
  output logic [`LINK_DATA_W-1:0] outData,
  output logic                    markValid,
  input  logic                    markReady
);

  linkPkg::dataToken_t headToken;

  elasticFifo #(
    .SIZE(`DATA_FIFO_DEPTH)
  ) dataFifo (
    .clk(clk),
    .rst(rst),
    .insValid(link.dataValid),
    .insData(link.dataToken),
    .insReady(),
    .outsValid(outValid),
    .outsData(headToken),
    .outsReady(outReady)
  );

  elasticFifoDataless #(
    .SIZE(`MARK_FIFO_DEPTH)
  ) markFifo (
    .clk(clk),
    .rst(rst),
    .insValid(link.markValid),
    .insReady(),
    .outsValid(markValid),
    .outsReady(markReady)
  );

  // Last is only needed on the link, marks carry the packet end downstream
  assign outData = headToken.value;

  // One credit back per pop, sent on the cycle after it
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      link.dataCredit <= 1'b0;
      link.markCredit <= 1'b0;
    end else begin
      link.dataCredit <= outValid && outReady;
      link.markCredit <= markValid && markReady;
    end
  end

endmodule

// ==== source/elasticLinkTop.sv ====
`timescale 1ns/10ps
`include "link_defs.svh"

module elasticLinkTop (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    inValid,
  output logic                    inReady,
  input  logic [`LINK_DATA_W-1:0] inData,
  input  logic                    inLast,
  output logic                    outValid,
  input  logic                    outReady,
  output logic [`LINK_DATA_W-1:0] outData,
  output logic                    markValid,
  input  logic                    markReady
);

  creditLinkIf link ();

  linkSender sender (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inReady(inReady),
    .inData(inData),
    .inLast(inLast),
    .link(link.sender)
  );

  linkReceiver receiver (
    .clk(clk),
    .rst(rst),
    .link(link.receiver),
    .outValid(outValid),
    .outReady(outReady),
    .outData(outData),
    .markValid(markValid),
    .markReady(markReady)
  );

endmodule

// ==== test/elasticLinkTb.sv ====
`timescale 1ns/10ps
`include "link_defs.svh"

module elasticLinkTb;

  logic                    clk;
  logic                    rst;
  logic                    inValid;
  logic                    inReady;
  logic [`LINK_DATA_W-1:0] inData;
  logic                    inLast;
  logic                    outValid;
  logic                    outReady;
  logic [`LINK_DATA_W-1:0] outData;
  logic                    markValid;
  logic                    markReady;

  // Stimulus table with one entry per token line of the file
  string                   tName[$];
  logic [`LINK_DATA_W-1:0] tVal[$];
  logic                    tLast[$];
  logic [`LINK_DATA_W-1:0] expQ[$];
  logic [`LINK_DATA_W-1:0] expVal;

  int    expTokens;
  int    expMarks;
  int    outCount;
  int    markSeen;
  int    lastAccepted;
  int    checks;
  int    errors;
  int    testStartErrors;
  int    tests;
  string curTest;

  // Ready modes are 0 random, 1 held low and 2 held high
  int          outMode;
  int          markMode;
  logic [31:0] lfsr;
  logic        nextOutReady;
  logic        nextMarkReady;

  elasticLinkTop dut (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inReady(inReady),
    .inData(inData),
    .inLast(inLast),
    .outValid(outValid),
    .outReady(outReady),
    .outData(outData),
    .markValid(markValid),
    .markReady(markReady)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois LFSR stepped once per random bit
  function automatic logic randomBit();
    logic b;
    b = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
    return b;
  endfunction

  function automatic logic readyFor(int mode);
    if (mode == 1) return 1'b0;
    if (mode == 2) return 1'b1;
    return randomBit();
  endfunction

  // Modes are taken at the edge and the ready levels applied just after it
  always @(posedge clk) begin
    nextOutReady  = readyFor(outMode);
    nextMarkReady = readyFor(markMode);
    #1;
    outReady  = nextOutReady;
    markReady = nextMarkReady;
  end

  // Output side scoreboard and mark ordering
  always @(posedge clk) begin
    if (!rst && outValid && outReady) begin
      checks++;
      outCount++;
      if (expQ.size() == 0) begin
        $display("Output token %h appeared in test %s with nothing accepted", outData, curTest);
        errors++;
      end else begin
        expVal = expQ.pop_front();
        if (outData !== expVal) begin
          $display("Fail %s expected %h actual %h", curTest, expVal, outData);
          errors++;
        end
      end
    end
    if (!rst && markValid && markReady) begin
      checks++;
      markSeen++;
      if (markSeen > lastAccepted) begin
        $display("Fail %s expected marks at most %0d actual %0d", curTest, lastAccepted,
                 markSeen);
        errors++;
      end
    end
  end

  function automatic int firstIndex(string name);
    foreach (tName[i]) begin
      if (tName[i] == name) return i;
    end
    return -1;
  endfunction

  function automatic int countOf(string name);
    int n;
    n = 0;
    foreach (tName[i]) begin
      if (tName[i] == name) n++;
    end
    return n;
  endfunction

  task automatic loadStimulus();
    int    fd;
    int    r;
    int    n;
    string line;
    string word;
    logic [`LINK_DATA_W-1:0] v;
    logic  l;
    fd = $fopen("test/linkStimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      r = $sscanf(line, "%s", word);
      if (n == 0 || r < 1 || word.substr(0, 0) == "#") continue;
      if (word == "tokens") begin
        r = $sscanf(line, "%s %d", word, expTokens);
      end else if (word == "marks") begin
        r = $sscanf(line, "%s %d", word, expMarks);
      end else begin
        r = $sscanf(line, "%s %h %h", word, v, l);
        tName.push_back(word);
        tVal.push_back(v);
        tLast.push_back(l);
      end
    end
    $fclose(fd);
  endtask

  // Present one token and hold it until the DUT takes it
  task automatic sendToken(int idx);
    int waitCycles;
    waitCycles = 0;
    inValid = 1'b1;
    inData  = tVal[idx];
    inLast  = tLast[idx];
    forever begin
      @(posedge clk);
      if (inReady) break;
      waitCycles++;
      if (waitCycles > 200) begin
        $display("Timed out in %s waiting for inReady", curTest);
        errors++;
        break;
      end
    end
    if (inReady) begin
      expQ.push_back(tVal[idx]);
      if (tLast[idx]) lastAccepted++;
    end
    #1;
    inValid = 1'b0;
  endtask

  // Offer tokens every cycle for a fixed window and count how many go in
  task automatic offerWindow(inout int idx, input int lastIdx, input int cycles,
                             output int accepted, output int packets);
    accepted = 0;
    packets  = 0;
    repeat (cycles) begin
      inValid = (idx <= lastIdx);
      if (idx <= lastIdx) begin
        inData = tVal[idx];
        inLast = tLast[idx];
      end
      @(posedge clk);
      if (inValid && inReady) begin
        expQ.push_back(tVal[idx]);
        accepted++;
        if (tLast[idx]) begin
          lastAccepted++;
          packets++;
        end
        idx++;
      end
      #1;
    end
    inValid = 1'b0;
  endtask

  task automatic waitDrain();
    int waitCycles;
    waitCycles = 0;
    while (expQ.size() != 0 || markSeen != lastAccepted) begin
      @(posedge clk);
      #1;
      waitCycles++;
      if (waitCycles > 400) begin
        $display("Timed out in %s waiting for the FIFOs to drain", curTest);
        errors++;
        break;
      end
    end
  endtask

  task automatic startTest(string name);
    curTest = name;
    testStartErrors = errors;
    tests++;
  endtask

  task automatic endTest();
    $display("Test %s finished with %0d errors", curTest, errors - testStartErrors);
  endtask

  initial begin
    int idx;
    int lastIdx;
    int accepted;
    int packets;
    lfsr = 32'h2a3a4c22;
    rst = 1'b1;
    inValid = 1'b0;
    inData = '0;
    inLast = 1'b0;
    outReady = 1'b0;
    markReady = 1'b0;
    outMode = 1;
    markMode = 1;
    loadStimulus();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    startTest("reset");
    @(posedge clk);
    checks++;
    if (outValid !== 1'b0 || markValid !== 1'b0 || inReady !== 1'b1) begin
      $display("Fail reset expected %b actual %b", 3'b001, {outValid, markValid, inReady});
      errors++;
    end
    #1;
    endTest();

    startTest("order");
    outMode = 0;
    markMode = 0;
    idx = firstIndex("order");
    for (int i = 0; i < countOf("order"); i++) sendToken(idx + i);
    waitDrain();
    endTest();

    startTest("credit");
    outMode = 1;
    idx = firstIndex("credit");
    lastIdx = idx + countOf("credit") - 1;
    offerWindow(idx, lastIdx, `DATA_FIFO_DEPTH + 26, accepted, packets);
    checks++;
    if (accepted != `DATA_FIFO_DEPTH) begin
      $display("Fail credit expected %0d actual %0d", `DATA_FIFO_DEPTH, accepted);
      errors++;
    end
    outMode = 2;
    while (idx <= lastIdx) begin
      sendToken(idx);
      idx++;
    end
    waitDrain();
    @(posedge clk);
    checks++;
    if (inReady !== 1'b1) begin
      $display("Fail credit expected %b actual %b", 1'b1, inReady);
      errors++;
    end
    #1;
    endTest();

    startTest("markbp");
    markMode = 1;
    outMode = 2;
    idx = firstIndex("markbp");
    lastIdx = idx + countOf("markbp") - 1;
    offerWindow(idx, lastIdx, 30, accepted, packets);
    checks++;
    if (packets != `MARK_FIFO_DEPTH + 1) begin
      $display("Fail markbp expected %0d actual %0d", `MARK_FIFO_DEPTH + 1, packets);
      errors++;
    end
    markMode = 2;
    while (idx <= lastIdx) begin
      sendToken(idx);
      idx++;
    end
    waitDrain();
    endTest();

    startTest("totals");
    checks++;
    if (outCount != expTokens) begin
      $display("Fail totals expected %0d actual %0d", expTokens, outCount);
      errors++;
    end
    checks++;
    if (markSeen != expMarks) begin
      $display("Fail totals expected %0d actual %0d", expMarks, markSeen);
      errors++;
    end
    endTest();

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== test/linkStimulus.txt ====
# Token lines: test name, value in hex, last flag
# Header lines: tokens <count>, marks <count> give the expected totals
tokens 19
marks 9
order a001 0
order a002 0
order a003 1
order a004 0
order a005 1
order a006 0
order a007 0
order a008 1
credit c001 0
credit c002 0
credit c003 0
credit c004 0
credit c005 0
credit c006 1
markbp b001 1
markbp b002 1
markbp b003 1
markbp b004 1
markbp b005 1

// ==== vlog.f ====
+incdir+source
source/linkPkg.sv
source/creditLinkIf.sv
source/creditCounter.sv
source/linkSender.sv
source/elasticFifo.sv
source/elasticFifoDataless.sv
source/linkReceiver.sv
source/elasticLinkTop.sv
test/elasticLinkTb.sv
